//--- verilog.f
common/axis_pkg.sv
common/arb_pkg.sv
logic/axis_ingress_pipe.sv
axis_mux/pkt_arbiter.sv
axis_mux/axis_egress_stage.sv
axis_mux/axis_pkt_mux.sv
testbench/tb_axis_pkt_mux.sv

//--- Makefile
# Verilator build and run for the AXI4-Stream packet mux.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axis_pkt_mux
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

# the run result is read from the log, not from the exit status.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_axis_pkt_mux.sv
// --------------------
// testbench for the packet mux, three ports in work-conserving mode.
// phase 1 keeps all ports busy and checks strict port rotation.
// phase 2 drives port 1 alone with idle gaps between beats.
// out_ready is randomly throttled for the whole run.
// --------------------

`timescale 1ns/1ps

module tb_axis_pkt_mux;
   import axis_pkg::*;
   import arb_pkg::*;

   localparam int          N_PORTS = 3;
   localparam int          P1_PKTS = 8;
   localparam int          P2_PKTS = 6;
   localparam int          MAX_PKTS = P1_PKTS + P2_PKTS;
   localparam int          MAX_LEN = 6;
   localparam int unsigned SEED = 32'h015a9cbd;

   logic                       aclk = 1'b0;
   logic                       arst_n;
   logic [N_PORTS-1:0]         in_valid;
   logic [N_PORTS-1:0]         in_ready;
   axis_beat_t [N_PORTS-1:0]   in_beat;
   logic                       out_valid;
   logic                       out_ready;
   axis_beat_t                 out_beat;

   // stimulus tables, filled once before reset.
   int   num_pkts [N_PORTS] = '{P1_PKTS, P1_PKTS + P2_PKTS, P1_PKTS};
   int   pkt_len [N_PORTS][MAX_PKTS];
   int   gap_len [N_PORTS][MAX_PKTS][MAX_LEN];
   int   phase1_beats = 0;
   int   total_beats = 0;
   int   timeout_cycles = 0;
   int   phase = 1;
   logic phase1_go = 1'b0;
   logic phase2_go = 1'b0;

   // scoreboard state.
   int   pkt_idx [N_PORTS] = '{default: 0};
   int   beat_idx [N_PORTS] = '{default: 0};
   int   beats_seen = 0;
   int   prev_port = N_PORTS - 1;
   logic in_pkt = 1'b0;
   tid_t cur_tid = '0;

   axis_pkt_mux #(.N_PORTS(N_PORTS), .MODE(ARB_WCRR)) dut0 (
      .aclk      (aclk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_beat   (in_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_beat  (out_beat)
   );

   // 20 ns clock.
   always #10 aclk = ~aclk;

   // --------------------
   // reference and checks
   // --------------------

   // beat number index of a packet, every field follows from port, packet and index.
   function automatic axis_beat_t expected_beat(input int port, input int packet,
                                                input int index);
      axis_beat_t b;
      logic       last;
      last    = (index == pkt_len[port][packet] - 1);
      b.tdata = {8'(port), 8'(packet), 8'(index), 8'(port * 37 + packet * 11 + index) ^ 8'h5a};
      // the last beat of a packet may be partial.
      b.tkeep = last ? (4'hf >> (packet % 4)) : 4'hf;
      b.tlast = last;
      b.tid   = tid_t'(port);
      b.tdest = tdest_t'(packet);
      b.tuser = tuser_t'(index + port);
      return b;
   endfunction

   task automatic abort_run(input string msg);
      $display("Failure at %0t ns: %s", $time, msg);
      $display("Testbench failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic compare_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         abort_run("egress beat mismatch");
      end
   endtask

   task automatic compare_tid(input string name, input tid_t got, input tid_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
         abort_run("egress port order mismatch");
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
         abort_run("control flag mismatch");
      end
   endtask

   // --------------------
   // stimulus
   // --------------------

   // one source per port, each holds valid and beat until the transfer.
   for (genvar g = 0; g < N_PORTS; g++) begin : g_src
      logic       src_valid;
      axis_beat_t src_beat;
      assign in_valid[g] = src_valid;
      assign in_beat[g]  = src_beat;

      initial begin
         src_valid = 1'b0;
         src_beat  = '0;
         wait (phase1_go);
         for (int k = 0; k < num_pkts[g]; k++) begin
            // phase 2 packets start once phase 1 has fully drained.
            if (k == P1_PKTS) begin
               src_valid <= 1'b0;
               wait (phase2_go);
               @(posedge aclk);
            end
            for (int i = 0; i < pkt_len[g][k]; i++) begin
               if (gap_len[g][k][i] > 0) begin
                  src_valid <= 1'b0;
                  repeat (gap_len[g][k][i]) @(posedge aclk);
               end
               src_valid <= 1'b1;
               src_beat  <= expected_beat(g, k, i);
               @(posedge aclk);
               while (!in_ready[g]) @(posedge aclk);
            end
         end
         src_valid <= 1'b0;
      end
   end

   // random back-pressure, about 70 percent ready.
   initial begin
      out_ready = 1'b0;
      forever begin
         @(posedge aclk);
         out_ready <= ($urandom_range(0, 99) < 70);
      end
   end

   // --------------------
   // monitor
   // --------------------
   always @(posedge aclk) begin : monitor
      int port;
      if (!arst_n) begin
         compare_flag("out_valid", out_valid, 1'b0);
         compare_flag("in_ready", |in_ready, 1'b0);
      end else if (out_valid && out_ready) begin
         port = int'(out_beat.tid);
         if (in_pkt) begin
            // no other port may cut into a packet.
            compare_tid("out_beat.tid", out_beat.tid, cur_tid);
         end else if (phase == 1) begin
            compare_tid("packet port", out_beat.tid, tid_t'((prev_port + 1) % N_PORTS));
         end else begin
            compare_tid("packet port", out_beat.tid, tid_t'(1));
         end
         if (port >= N_PORTS) begin
            abort_run("egress beat carries a tid with no matching port");
         end else if (pkt_idx[port] >= num_pkts[port]) begin
            abort_run("egress carries more packets than were sent");
         end else begin
            compare_beat("out_beat", out_beat,
                         expected_beat(port, pkt_idx[port], beat_idx[port]));
            beats_seen = beats_seen + 1;
            cur_tid    = out_beat.tid;
            if (out_beat.tlast) begin
               pkt_idx[port]  = pkt_idx[port] + 1;
               beat_idx[port] = 0;
               prev_port      = port;
               in_pkt         = 1'b0;
            end else begin
               beat_idx[port] = beat_idx[port] + 1;
               in_pkt         = 1'b1;
            end
         end
      end
   end

   // watchdog, sized from the beat count.
   initial begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge aclk);
      abort_run("timeout, the egress did not deliver every beat in time");
   end

   // --------------------
   // run control
   // --------------------
   initial begin
      logic count_ok;
      void'($urandom(SEED));
      arst_n   = 1'b1;
      count_ok = 1'b1;
      for (int p = 0; p < N_PORTS; p++) begin
         for (int k = 0; k < MAX_PKTS; k++) begin
            pkt_len[p][k] = (k < num_pkts[p]) ? int'($urandom_range(1, MAX_LEN)) : 0;
            for (int i = 0; i < MAX_LEN; i++) begin
               gap_len[p][k][i] = (k >= P1_PKTS) ? int'($urandom_range(0, 3)) : 0;
            end
            if (k < P1_PKTS) phase1_beats = phase1_beats + pkt_len[p][k];
            total_beats = total_beats + pkt_len[p][k];
         end
      end
      timeout_cycles = 40 * total_beats + 200;
      #1 arst_n = 1'b0;
      repeat (8) @(posedge aclk);
      arst_n <= 1'b1;
      @(posedge aclk);
      phase1_go = 1'b1;
      wait (beats_seen == phase1_beats);
      phase     = 2;
      phase2_go = 1'b1;
      wait (beats_seen == total_beats);
      // extra cycles so a duplicated beat would still show up.
      repeat (20) @(posedge aclk);
      for (int p = 0; p < N_PORTS; p++) begin
         if (pkt_idx[p] != num_pkts[p] || beat_idx[p] != 0) count_ok = 1'b0;
      end
      if (!count_ok || beats_seen != total_beats) begin
         abort_run("received beat count differs from the count sent");
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule : tb_axis_pkt_mux

//--- axis_mux/axis_pkt_mux.sv
// --------------------
// AXI4-Stream packet mux, N_PORTS ingress onto one egress.
// all ports share aclk. N_PORTS must be at least 2.
// minimum latency is two cycles, packets never interleave.
// --------------------

`timescale 1ns/1ps

module axis_pkt_mux #(
   parameter int                 N_PORTS = 3,
   parameter arb_pkg::arb_mode_e MODE    = arb_pkg::ARB_WCRR
) (
   input  logic                                aclk,
   input  logic                                arst_n,
   input  logic [N_PORTS-1:0]                  in_valid,
   output logic [N_PORTS-1:0]                  in_ready,
   input  axis_pkg::axis_beat_t [N_PORTS-1:0]  in_beat,
   output logic                                out_valid,
   input  logic                                out_ready,
   output axis_pkg::axis_beat_t                out_beat
);
   import axis_pkg::*;

   // --------------------
   // internal wiring
   // --------------------
   logic [N_PORTS-1:0]               pipe_valid;
   logic [N_PORTS-1:0]               pipe_ready;
   axis_beat_t [N_PORTS-1:0]         pipe_beat;
   // tlast of each buffered beat, for the arbiter.
   logic [N_PORTS-1:0]               pipe_last;
   logic [$clog2(N_PORTS)-1:0]       sel;
   logic                             sel_valid;
   logic                             take;

   // one skid buffer per ingress port.
   for (genvar g = 0; g < N_PORTS; g++) begin : g_port
      axis_ingress_pipe u_pipe (
         .aclk       (aclk),
         .arst_n     (arst_n),
         .in_valid   (in_valid[g]),
         .in_ready   (in_ready[g]),
         .in_beat    (in_beat[g]),
         .pipe_valid (pipe_valid[g]),
         .pipe_ready (pipe_ready[g]),
         .pipe_beat  (pipe_beat[g])
      );
      assign pipe_last[g] = pipe_beat[g].tlast;
   end

   pkt_arbiter #(.N_PORTS(N_PORTS), .MODE(MODE)) u_arb (
      .aclk      (aclk),
      .arst_n    (arst_n),
      .req       (pipe_valid),
      .req_last  (pipe_last),
      .take      (take),
      .sel       (sel),
      .sel_valid (sel_valid)
   );

   // merges beats from the pipes with the grant.
   axis_egress_stage #(.N_PORTS(N_PORTS)) u_egress (
      .aclk       (aclk),
      .arst_n     (arst_n),
      .pipe_valid (pipe_valid),
      .pipe_beat  (pipe_beat),
      .pipe_ready (pipe_ready),
      .sel        (sel),
      .sel_valid  (sel_valid),
      .take       (take),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_beat   (out_beat)
   );

endmodule : axis_pkt_mux

//--- axis_mux/axis_egress_stage.sv
// --------------------
// egress register for the packet mux.
// only the granted port sees pipe_ready.
// one cycle from take to out_valid.
// --------------------

`timescale 1ns/1ps

module axis_egress_stage #(
   parameter int N_PORTS = 3
) (
   input  logic                                aclk,
   input  logic                                arst_n,
   input  logic [N_PORTS-1:0]                  pipe_valid,
   input  axis_pkg::axis_beat_t [N_PORTS-1:0]  pipe_beat,
   output logic [N_PORTS-1:0]                  pipe_ready,
   input  logic [$clog2(N_PORTS)-1:0]          sel,
   input  logic                                sel_valid,
   output logic                                take,
   output logic                                out_valid,
   input  logic                                out_ready,
   output axis_pkg::axis_beat_t                out_beat
);
   import axis_pkg::*;

   // beat of the granted port.
   axis_beat_t sel_beat;
   // register empty or draining this cycle.
   logic       can_accept;

   assign sel_beat   = pipe_beat[sel];
   assign can_accept = !out_valid || out_ready;
   assign take       = sel_valid && pipe_valid[sel] && can_accept;

   // --------------------
   // ready fan-out
   // --------------------
   for (genvar g = 0; g < N_PORTS; g++) begin : g_ready
      assign pipe_ready[g] = can_accept && sel_valid && (int'(sel) == g);
   end

   // output valid.
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (can_accept) begin
         out_valid <= take;
      end
   end

   // output payload.
   always_ff @(posedge aclk) begin
      if (take) out_beat <= sel_beat;
   end

   // held beat waits for out_ready, per AXI4-Stream.
   a_out_hold : assert property (@(posedge aclk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule : axis_egress_stage

//--- axis_mux/pkt_arbiter.sv
// --------------------
// packet-locked round-robin arbiter.
// N_PORTS must be at least 2.
// the grant is held from the first beat of a packet through its tlast beat.
// in idle state sel follows req in the same cycle.
// --------------------

`timescale 1ns/1ps

module pkt_arbiter #(
   parameter int                 N_PORTS = 3,
   parameter arb_pkg::arb_mode_e MODE    = arb_pkg::ARB_WCRR
) (
   input  logic                       aclk,
   input  logic                       arst_n,
   input  logic [N_PORTS-1:0]         req,
   input  logic [N_PORTS-1:0]         req_last,
   input  logic                       take,
   output logic [$clog2(N_PORTS)-1:0] sel,
   output logic                       sel_valid
);
   import arb_pkg::*;

   localparam int SEL_W = $clog2(N_PORTS);

   arb_state_e       state;
   logic [SEL_W-1:0] lock_port;
   // the search starts after the last port granted.
   logic [SEL_W-1:0] ptr;

   logic [SEL_W-1:0] pick;
   logic             pick_valid;

   // port at base plus offset wrapped at N_PORTS.
   function automatic logic [SEL_W-1:0] wrap_port(input logic [SEL_W-1:0] base,
                                                  input int offset);
      int sum;
      sum = int'(base) + offset;
      return SEL_W'(sum % N_PORTS);
   endfunction

   // --------------------
   // idle choice
   // --------------------
   always_comb begin
      pick       = wrap_port(ptr, 1);
      pick_valid = req[pick];
      if (MODE == ARB_WCRR) begin
         pick_valid = 1'b0;
         // walk downward so the nearest port after ptr wins.
         for (int i = N_PORTS; i >= 1; i--) begin
            if (req[wrap_port(ptr, i)]) begin
               pick       = wrap_port(ptr, i);
               pick_valid = 1'b1;
            end
         end
      end
   end

   // a locked packet keeps its port and a bubble only drops sel_valid.
   assign sel       = (state == ARB_LOCKED) ? lock_port : pick;
   assign sel_valid = (state == ARB_LOCKED) ? req[lock_port] : pick_valid;

   // --------------------
   // lock and pointer
   // --------------------
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ARB_IDLE;
         lock_port <= '0;
         ptr       <= SEL_W'(N_PORTS - 1);
      end else if (take) begin
         if (req_last[sel]) begin
            // the next search starts after the port that just finished.
            state <= ARB_IDLE;
            ptr   <= sel;
         end else begin
            state     <= ARB_LOCKED;
            lock_port <= sel;
         end
      end
   end

   // no port switch inside a packet.
   a_lock_hold : assert property (@(posedge aclk) disable iff (!arst_n)
      ((state == ARB_LOCKED) || take) && !(take && req_last[sel]) |=> $stable(sel));

   // an idle work-conserving arbiter grants a waiting port as soon as any port asks.
   a_grant_req : assert property (@(posedge aclk) disable iff (!arst_n)
      (MODE == ARB_WCRR) && (state == ARB_IDLE) && (|req) |-> sel_valid && req[sel]);

endmodule : pkt_arbiter

//--- logic/axis_ingress_pipe.sv
// --------------------
// two-entry skid buffer for one AXI4-Stream port.
// in_ready is a register and never follows pipe_ready in the same cycle.
// in_ready stays low for one cycle after reset is released.
// --------------------

`timescale 1ns/1ps

module axis_ingress_pipe (
   input  logic                  aclk,
   input  logic                  arst_n,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  axis_pkg::axis_beat_t  in_beat,
   output logic                  pipe_valid,
   input  logic                  pipe_ready,
   output axis_pkg::axis_beat_t  pipe_beat
);
   import axis_pkg::*;

   // skid entry used only when the main entry is stalled.
   axis_beat_t skid_beat;
   logic       skid_valid;

   logic in_fire;
   logic main_valid_nxt;
   logic skid_valid_nxt;
   logic load_from_in;
   logic load_from_skid;
   logic load_skid;

   assign in_fire = in_valid && in_ready;

   // --------------------
   // next state
   // --------------------
   always_comb begin
      main_valid_nxt = pipe_valid;
      skid_valid_nxt = skid_valid;
      load_from_in   = 1'b0;
      load_from_skid = 1'b0;
      load_skid      = 1'b0;
      // main entry is free or drains this cycle.
      if (!pipe_valid || pipe_ready) begin
         if (skid_valid) begin
            // in_ready is low while the skid entry is full.
            main_valid_nxt = 1'b1;
            load_from_skid = 1'b1;
            skid_valid_nxt = 1'b0;
         end else begin
            main_valid_nxt = in_fire;
            load_from_in   = in_fire;
         end
      end else if (in_fire) begin
         // the main entry is stalled so the new beat parks in the skid entry.
         skid_valid_nxt = 1'b1;
         load_skid      = 1'b1;
      end
   end

   // control state.
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         pipe_valid <= 1'b0;
         skid_valid <= 1'b0;
         in_ready   <= 1'b0;
      end else begin
         pipe_valid <= main_valid_nxt;
         skid_valid <= skid_valid_nxt;
         // accept again only while the skid entry is empty.
         in_ready   <= !skid_valid_nxt;
      end
   end

   // payload registers.
   always_ff @(posedge aclk) begin
      if (load_from_skid) pipe_beat <= skid_beat;
      else if (load_from_in) pipe_beat <= in_beat;
      if (load_skid) skid_beat <= in_beat;
   end

   // a stalled beat holds until the egress stage takes it.
   a_stall_stable : assert property (@(posedge aclk) disable iff (!arst_n)
      pipe_valid && !pipe_ready |=> pipe_valid && $stable(pipe_beat));

endmodule : axis_ingress_pipe

//--- common/arb_pkg.sv
// --------------------
// arbitration enums for the packet arbiter.
// the mode is fixed at elaboration through a module parameter.
// --------------------

package arb_pkg;

   // arbitration mode.
   // ARB_RR waits on the port whose turn it is.
   // ARB_WCRR skips ports with nothing to send.
   typedef enum logic {
      ARB_RR   = 1'b0,
      ARB_WCRR = 1'b1
   } arb_mode_e;

   // arbiter lock state.
   // ARB_LOCKED holds the grant until the tlast beat is taken.
   typedef enum logic {
      ARB_IDLE   = 1'b0,
      ARB_LOCKED = 1'b1
   } arb_state_e;

endpackage : arb_pkg

//--- common/axis_pkg.sv
// --------------------
// stream beat layout shared by every block that carries AXI4-Stream data.
// tvalid and tready stay outside the struct and travel as separate wires.
// widths are fixed here, so the whole design shares one beat format.
// --------------------

package axis_pkg;

   // --------------------
   // field widths
   // --------------------

   // data bytes per beat.
   localparam int DATA_BYTES = 4;
   // side field widths.
   localparam int TID_W      = 2;
   localparam int TDEST_W    = 2;
   localparam int TUSER_W    = 4;

   // --------------------
   // field types
   // --------------------

   typedef logic [TID_W-1:0]   tid_t;
   typedef logic [TDEST_W-1:0] tdest_t;
   typedef logic [TUSER_W-1:0] tuser_t;

   // one beat of payload and sideband.
   // tdata is byte addressed, byte 0 in the low bits.
   typedef struct packed {
      logic [DATA_BYTES-1:0][7:0] tdata;
      logic [DATA_BYTES-1:0]      tkeep;
      logic                       tlast;
      tid_t                       tid;
      tdest_t                     tdest;
      tuser_t                     tuser;
   } axis_beat_t;

endpackage : axis_pkg
